// ==== src.f ====
+incdir+.
uart_rx_pkg.sv
uart_baud_gen.sv
uart_rx_sampler.sv
uart_rx_frame.sv
uart_rx_out_queue.sv
uart_rx_top.sv
tb_uart_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module tb_uart_rx -f src.f -o tb_uart_rx \
    > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$build_log"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/tb_uart_rx > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "Some tests failed" "$sim_log"; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "RESULT: PASS"
exit 0

// ==== tb_uart_rx.sv ====
`timescale 1ns/10ps
`include "uart_rx_defines.svh"

module tb_uart_rx;

    typedef struct packed {
        logic [2:0]             baud;
        logic [7:0]             data;
        logic                   parity_bit;  // As driven on the line
        logic                   stop_bit;
        logic                   glitch;      // Short low pulse that makes no frame
        logic [3:0]             drop_bit;    // Bit where rx_enable falls or 0 for none
        logic                   hold;        // Sent with credits withheld
        logic                   deliver;     // Must reach the output
        uart_rx_pkg::rx_entry_t expect_entry;
    } row_t;

    logic       clk;
    logic       reset;
    logic [2:0] baud_select;
    logic       rx_enable;
    logic       rxd;
    logic       credit_return = 1'b0;
    logic       out_valid;
    logic [7:0] out_data;
    logic       out_perror;
    logic       out_ferror;
    logic       overrun;

    row_t                   rows[$];
    uart_rx_pkg::rx_entry_t exp_q[$];     // Frames still due at the output
    int   pending = 0;       // Frames held by the consumer
    int   ret_wait = 0;      // Cycles to next credit return
    int   out_count = 0;     // All frames seen at the output
    int   held_base;         // out_count when credits were withheld
    int   held_rows;
    int   hold_idx;          // Position in a withheld run while building the table
    logic hold_credits;
    logic overrun_exp;
    int   cycle_cnt = 0;
    int   cycle_limit = 0;

    uart_rx_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .baud_select   (baud_select),
        .rx_enable     (rx_enable),
        .rxd           (rxd),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_perror    (out_perror),
        .out_ferror    (out_ferror),
        .overrun       (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Clocks per sample tick
    function automatic int div_of(input logic [2:0] sel);
        case (sel)
            3'd0:    return `UART_DIV_0;
            3'd1:    return `UART_DIV_1;
            3'd2:    return `UART_DIV_2;
            3'd3:    return `UART_DIV_3;
            3'd4:    return `UART_DIV_4;
            3'd5:    return `UART_DIV_5;
            3'd6:    return `UART_DIV_6;
            default: return `UART_DIV_7;
        endcase
    endfunction

    function automatic void add_row(input logic [2:0] baud, input logic [7:0] data,
                                    input logic bad_parity, input logic low_stop,
                                    input logic glitch, input logic [3:0] drop_bit,
                                    input logic hold);
        row_t r;
        r.baud                = baud;
        r.data                = data;
        r.parity_bit          = (^data) ^ bad_parity;  // Even parity unless corrupted
        r.stop_bit            = ~low_stop;
        r.glitch              = glitch;
        r.drop_bit            = drop_bit;
        r.hold                = hold;
        r.expect_entry.data   = data;
        r.expect_entry.perror = bad_parity;  // Only a flipped parity bit is an error
        r.expect_entry.ferror = low_stop;
        if (hold) begin
            // Credits plus queue slots absorb the first frames of a run
            r.deliver = (hold_idx < `UART_RX_CREDITS + `UART_RX_QDEPTH);
            hold_idx++;
        end else begin
            r.deliver = !glitch && (drop_bit == 4'd0);
            hold_idx  = 0;
        end
        rows.push_back(r);
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_entry(input string name, input uart_rx_pkg::rx_entry_t got,
                               input uart_rx_pkg::rx_entry_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t %s: expected %h/%b/%b got %h/%b/%b",
                                     $time, name, exp.data, exp.perror, exp.ferror,
                                     got.data, got.perror, got.ferror));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t %s: expected %b got %b",
                                     $time, name, exp, got));
        end
    endtask

    // Serial line driver sending LSB first and then two idle bits
    task automatic drive_row(input row_t r);
        int          bit_clks;
        logic [10:0] bits;
        bit_clks = `UART_OVERSAMPLE * div_of(r.baud);
        bits     = {r.stop_bit, r.parity_bit, r.data, 1'b0};
        if (r.glitch) begin
            rxd = 1'b0;
            repeat (bit_clks / 4) @(negedge clk);  // Quarter bit is well under half
        end else begin
            for (int i = 0; i < 11; i++) begin
                if (r.drop_bit != 4'd0 && i == int'(r.drop_bit)) rx_enable = 1'b0;
                rxd = bits[i];
                repeat (bit_clks) @(negedge clk);
            end
        end
        rxd = 1'b1;
        repeat (2 * bit_clks) @(negedge clk);
        if (!rx_enable) begin
            rx_enable = 1'b1;  // Wake up on an idle line
            repeat (4) @(negedge clk);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic begin_hold();
        drain();  // All credits back in the DUT
        hold_credits = 1'b1;
        held_base    = out_count;
        held_rows    = 0;
    endtask

    task automatic end_hold();
        int allowed;
        allowed = (held_rows < `UART_RX_CREDITS) ? held_rows : `UART_RX_CREDITS;
        repeat (20) @(negedge clk);
        if (out_count - held_base != allowed) begin
            report_failure($sformatf("Saw %0d frames while credits were withheld, %0d allowed",
                                     out_count - held_base, allowed));
        end
        hold_credits = 1'b0;
        drain();  // Queued frames released in order
        if (held_rows > `UART_RX_CREDITS + `UART_RX_QDEPTH) overrun_exp = 1'b1;
        check_bit("overrun", overrun, overrun_exp);
    endtask

    // Output monitor and credit-returning consumer
    always @(negedge clk) begin
        uart_rx_pkg::rx_entry_t got;
        if (!reset) begin
            credit_return = 1'b0;
            if (out_valid) begin
                got.data   = out_data;
                got.perror = out_perror;
                got.ferror = out_ferror;
                if (exp_q.size() == 0) begin
                    report_failure($sformatf("Unexpected frame %h at %0t", out_data, $time));
                end else if (pending >= `UART_RX_CREDITS) begin
                    report_failure("Frame delivered while the consumer had no free slot");
                end else begin
                    check_entry("out_data/out_perror/out_ferror", got, exp_q.pop_front());
                    pending++;
                    out_count++;
                end
            end
            if (pending > 0 && !hold_credits) begin
                if (ret_wait == 0) begin
                    credit_return = 1'b1;  // Slot freed
                    pending--;
                    ret_wait = $urandom_range(6, 0);
                end else begin
                    ret_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            report_failure($sformatf("Timeout after %0d cycles, expected frames never came",
                                     cycle_cnt));
        end
    end

    initial begin
        int frame_clks;
        void'($urandom(32'h9211));
        reset        = 1'b1;
        baud_select  = 3'd0;
        rx_enable    = 1'b1;
        rxd          = 1'b1;
        hold_credits = 1'b0;
        overrun_exp  = 1'b0;
        held_base    = 0;
        held_rows    = 0;
        hold_idx     = 0;
        frame_clks   = 0;

        // Clean frames at several rates
        add_row(3'd0, 8'h55, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd3, 8'hA3, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd7, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        // Parity error and low stop bit each followed by a clean frame
        add_row(3'd1, 8'($urandom), 1'b1, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd1, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd2, 8'h3C, 1'b0, 1'b1, 1'b0, 4'd0, 1'b0);
        add_row(3'd2, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        // Glitch on the line
        add_row(3'd4, 8'h00, 1'b0, 1'b0, 1'b1, 4'd0, 1'b0);
        add_row(3'd4, 8'h81, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        // rx_enable drops during data bit 3
        add_row(3'd5, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd4, 1'b0);
        add_row(3'd5, 8'hE7, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd6, 8'h00, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        add_row(3'd0, 8'hFF, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        // Withheld run that fits in credits plus queue
        for (int i = 0; i < `UART_RX_CREDITS + `UART_RX_QDEPTH; i++) begin
            add_row(3'(i % 2), 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b1);
        end
        add_row(3'd2, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);
        // Withheld run two frames too long for the queue
        for (int i = 0; i < `UART_RX_CREDITS + `UART_RX_QDEPTH + 2; i++) begin
            add_row(3'd0, 8'($urandom), 1'(i == 3), 1'b0, 1'b0, 4'd0, 1'b1);
        end
        add_row(3'd1, 8'($urandom), 1'b0, 1'b0, 1'b0, 4'd0, 1'b0);

        foreach (rows[i]) frame_clks += 13 * `UART_OVERSAMPLE * div_of(rows[i].baud);
        cycle_limit = frame_clks * 2 + 2000;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("overrun", overrun, 1'b0);

        foreach (rows[i]) begin
            if (rows[i].hold && !hold_credits) begin
                begin_hold();
            end else if (!rows[i].hold && hold_credits) begin
                end_hold();
            end
            if (rows[i].hold) held_rows++;
            baud_select = rows[i].baud;
            repeat (4) @(negedge clk);  // Divider restarts on a new rate
            if (rows[i].deliver) exp_q.push_back(rows[i].expect_entry);
            drive_row(rows[i]);
        end
        if (hold_credits) end_hold();
        drain();
        repeat (200) @(negedge clk);  // Stray output would show up here
        check_bit("overrun", overrun, overrun_exp);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== uart_rx_top.sv ====
`timescale 1ns/10ps

module uart_rx_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] baud_select,
    input  logic       rx_enable,
    input  logic       rxd,
    input  logic       credit_return,
    output logic       out_valid,
    output logic [7:0] out_data,
    output logic       out_perror,
    output logic       out_ferror,
    output logic       overrun
);

    logic       sample_tick;  // 16x bit rate strobe
    logic       start_seen;
    logic       bit_valid;
    logic       bit_value;
    logic       frame_busy;
    logic       push;
    logic [7:0] entry_data;
    logic       entry_perror;
    logic       entry_ferror;

    uart_baud_gen i_baud_gen (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .sample_tick (sample_tick)
    );

    // Decodes the line into bits
    uart_rx_sampler i_sampler (
        .clk         (clk),
        .reset       (reset),
        .rxd         (rxd),
        .sample_tick (sample_tick),
        .frame_busy  (frame_busy),
        .start_seen  (start_seen),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value)
    );

    // Runs the frame protocol
    uart_rx_frame i_frame (
        .clk          (clk),
        .reset        (reset),
        .rx_enable    (rx_enable),
        .start_seen   (start_seen),
        .bit_valid    (bit_valid),
        .bit_value    (bit_value),
        .frame_busy   (frame_busy),
        .push         (push),
        .entry_data   (entry_data),
        .entry_perror (entry_perror),
        .entry_ferror (entry_ferror)
    );

    // Delivers frames under credit control
    uart_rx_out_queue i_out_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .entry_data    (entry_data),
        .entry_perror  (entry_perror),
        .entry_ferror  (entry_ferror),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_perror    (out_perror),
        .out_ferror    (out_ferror),
        .overrun       (overrun)
    );

endmodule

// ==== uart_rx_out_queue.sv ====
`timescale 1ns/10ps
`include "uart_rx_defines.svh"

module uart_rx_out_queue (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] entry_data,
    input  logic       entry_perror,
    input  logic       entry_ferror,
    input  logic       credit_return,
    output logic       out_valid,
    output logic [7:0] out_data,
    output logic       out_perror,
    output logic       out_ferror,
    output logic       overrun
);

    localparam int DEPTH = `UART_RX_QDEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`UART_RX_CREDITS + 1);

    uart_rx_pkg::rx_entry_t mem [DEPTH];
    uart_rx_pkg::rx_entry_t in_entry;
    uart_rx_pkg::rx_entry_t send_entry;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W-1:0]       wr_ptr;
    logic [CNT_W-1:0]       fill;      // Entries held
    logic [CRD_W-1:0]       credits;   // Free consumer slots
    logic                   full;
    logic                   credit_ok;
    logic                   pop;       // Send from the buffer
    logic                   bypass;    // Send the incoming entry directly
    logic                   send;
    logic                   store;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_entry   = '{data: entry_data, perror: entry_perror, ferror: entry_ferror};
    assign full       = (fill == CNT_W'(DEPTH));
    assign credit_ok  = (credits != '0) || credit_return; // Returned credit usable at once
    assign pop        = credit_ok && (fill != '0);
    assign bypass     = credit_ok && (fill == '0) && push;
    assign send       = pop || bypass;
    assign store      = push && !bypass && (!full || pop); // Pop frees a slot this cycle
    assign send_entry = bypass ? in_entry : mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            fill      <= '0;
            credits   <= CRD_W'(`UART_RX_CREDITS);
            out_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            out_valid <= send; // One cycle per frame
            if (store) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({store, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({credit_return, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits; // Both or neither
            endcase
            if (push && full && !pop) begin
                overrun <= 1'b1; // Sticky until reset, frame dropped
            end
        end
    end

    // Storage and output payload
    always_ff @(posedge clk) begin
        if (store) mem[wr_ptr] <= in_entry;
        if (send) begin
            out_data   <= send_entry.data;
            out_perror <= send_entry.perror;
            out_ferror <= send_entry.ferror;
        end
    end

endmodule

// ==== uart_rx_frame.sv ====
`timescale 1ns/10ps

module uart_rx_frame (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_enable,
    input  logic       start_seen,
    input  logic       bit_valid,
    input  logic       bit_value,
    output logic       frame_busy,
    output logic       push,
    output logic [7:0] entry_data,
    output logic       entry_perror,
    output logic       entry_ferror
);

    uart_rx_pkg::frame_state_t state;
    uart_rx_pkg::frame_state_t state_next;
    logic [7:0]                shift_reg;  // Data bits, LSB arrives first
    logic [2:0]                bit_cnt;    // Data bits taken so far
    logic                      parity_bit;
    uart_rx_pkg::rx_entry_t    entry_q;    // Finished frame for the queue

    // Sampler stays in TRACK while this is high
    assign frame_busy = (state == uart_rx_pkg::START)  ||
                        (state == uart_rx_pkg::DATA)   ||
                        (state == uart_rx_pkg::PARITY) ||
                        (state == uart_rx_pkg::STOP);

    assign entry_data   = entry_q.data;
    assign entry_perror = entry_q.perror;
    assign entry_ferror = entry_q.ferror;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            uart_rx_pkg::DISABLED: begin
                state_next = uart_rx_pkg::IDLE;     // Wake when enabled
            end
            uart_rx_pkg::IDLE: begin
                if (start_seen) begin
                    state_next = uart_rx_pkg::START;
                end
            end
            uart_rx_pkg::START: begin
                state_next = uart_rx_pkg::DATA;     // Single cycle
            end
            uart_rx_pkg::DATA: begin
                if (bit_valid && bit_cnt == 3'd7) begin
                    state_next = uart_rx_pkg::PARITY; // Eighth data bit
                end
            end
            uart_rx_pkg::PARITY: begin
                if (bit_valid) begin
                    state_next = uart_rx_pkg::STOP;
                end
            end
            uart_rx_pkg::STOP: begin
                if (bit_valid) begin
                    state_next = uart_rx_pkg::IDLE;   // Errors do not lock
                end
            end
            default: begin
                state_next = uart_rx_pkg::DISABLED;
            end
        endcase
        // Sleep overrides everything, partial frame is lost
        if (!rx_enable) begin
            state_next = uart_rx_pkg::DISABLED;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= uart_rx_pkg::DISABLED;
            bit_cnt <= '0;
            push    <= 1'b0;
        end else begin
            state <= state_next;
            // One push per completed frame, none when disabled
            push  <= rx_enable && bit_valid && (state == uart_rx_pkg::STOP);
            if (state == uart_rx_pkg::START) begin
                bit_cnt <= '0;
            end else if (state == uart_rx_pkg::DATA && bit_valid) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // Frame contents and checks
    always_ff @(posedge clk) begin
        if (state == uart_rx_pkg::DATA && bit_valid) begin
            shift_reg <= {bit_value, shift_reg[7:1]}; // Shift right, LSB first
        end
        if (state == uart_rx_pkg::PARITY && bit_valid) begin
            parity_bit <= bit_value;
        end
        if (state == uart_rx_pkg::STOP && bit_valid) begin
            entry_q.data   <= shift_reg;
            entry_q.perror <= ^{shift_reg, parity_bit}; // Even parity, odd count is an error
            entry_q.ferror <= ~bit_value;               // Stop bit must be high
        end
    end

endmodule

// ==== uart_rx_sampler.sv ====
`timescale 1ns/10ps
`include "uart_rx_defines.svh"

module uart_rx_sampler (
    input  logic clk,
    input  logic reset,
    input  logic rxd,
    input  logic sample_tick,
    input  logic frame_busy,
    output logic start_seen,
    output logic bit_valid,
    output logic bit_value
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] SAMPLE_A  = TICK_W'(`UART_OVERSAMPLE / 2 - 1); // Sample 7
    localparam logic [TICK_W-1:0] SAMPLE_B  = TICK_W'(`UART_OVERSAMPLE / 2);     // Sample 8
    localparam logic [TICK_W-1:0] SAMPLE_C  = TICK_W'(`UART_OVERSAMPLE / 2 + 1); // Sample 9

    uart_rx_pkg::sampler_state_t state;
    logic              rxd_meta;  // First sync stage
    logic              rxd_sync;  // Second sync stage
    logic              rxd_prev;  // For edge detect
    logic [TICK_W-1:0] tick_cnt;  // Tick index within bit
    logic              in_start;  // Still inside start bit
    logic              samp_a;
    logic              samp_b;
    logic              vote;
    logic              fall_edge;

    assign fall_edge = rxd_prev & ~rxd_sync;
    // Majority of the two held samples and the live one
    assign vote = (samp_a & samp_b) | (samp_a & rxd_sync) | (samp_b & rxd_sync);

    // Line idles high, so sync flops reset to 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= uart_rx_pkg::HUNT;
            tick_cnt   <= '0;
            in_start   <= 1'b0;
            start_seen <= 1'b0;
            bit_valid  <= 1'b0;
        end else begin
            start_seen <= 1'b0;
            bit_valid  <= 1'b0;
            case (state)
                uart_rx_pkg::HUNT: begin
                    if (fall_edge) begin
                        state    <= uart_rx_pkg::TRACK; // Possible start bit
                        tick_cnt <= '0;
                        in_start <= 1'b1;
                    end
                end
                uart_rx_pkg::TRACK: begin
                    // Frame over, aborted, or never taken up by the receiver
                    if (!in_start && !frame_busy && !start_seen) begin
                        state <= uart_rx_pkg::HUNT;
                    end else if (sample_tick) begin
                        tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
                        if (tick_cnt == SAMPLE_C) begin
                            if (!in_start) begin
                                bit_valid <= 1'b1;        // Data, parity or stop
                            end else if (!vote) begin
                                start_seen <= 1'b1;       // Real start bit
                                in_start   <= 1'b0;
                            end else begin
                                state <= uart_rx_pkg::HUNT; // False start, glitch
                            end
                        end
                    end
                end
                default: state <= uart_rx_pkg::HUNT;
            endcase
        end
    end

    // Vote samples and decided bit
    always_ff @(posedge clk) begin
        if (sample_tick && tick_cnt == SAMPLE_A) samp_a <= rxd_sync;
        if (sample_tick && tick_cnt == SAMPLE_B) samp_b <= rxd_sync;
        if (sample_tick && tick_cnt == SAMPLE_C) bit_value <= vote;
    end

endmodule

// ==== uart_baud_gen.sv ====
`timescale 1ns/10ps
`include "uart_rx_defines.svh"

module uart_baud_gen (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] baud_select,
    output logic       sample_tick
);

    logic [7:0] div_cycles; // Period of one sample tick
    logic [7:0] cnt;        // Cycles left in current period
    logic [2:0] sel_q;      // Last seen baud_select

    // Divisor table lookup
    always_comb begin
        case (baud_select)
            3'd0:    div_cycles = 8'(`UART_DIV_0);
            3'd1:    div_cycles = 8'(`UART_DIV_1);
            3'd2:    div_cycles = 8'(`UART_DIV_2);
            3'd3:    div_cycles = 8'(`UART_DIV_3);
            3'd4:    div_cycles = 8'(`UART_DIV_4);
            3'd5:    div_cycles = 8'(`UART_DIV_5);
            3'd6:    div_cycles = 8'(`UART_DIV_6);
            default: div_cycles = 8'(`UART_DIV_7);
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt         <= '0;
            sel_q       <= '0;
            sample_tick <= 1'b0;
        end else if (baud_select != sel_q) begin
            sel_q       <= baud_select;        // New rate, restart the period
            cnt         <= div_cycles - 8'd1;
            sample_tick <= 1'b0;               // Drop the stale tick
        end else if (cnt == '0) begin
            cnt         <= div_cycles - 8'd1;  // Reload
            sample_tick <= 1'b1;
        end else begin
            cnt         <= cnt - 8'd1;
            sample_tick <= 1'b0;
        end
    end

endmodule

// ==== uart_rx_pkg.sv ====
package uart_rx_pkg;

    // Frame receiver FSM states
    typedef enum logic [2:0] {
        DISABLED = 3'd0, // Asleep, rx_enable low
        IDLE     = 3'd1, // Waiting for start_seen
        START    = 3'd2, // Start bit accepted, one cycle
        DATA     = 3'd3, // Eight data bits, LSB first
        PARITY   = 3'd4, // Even parity bit
        STOP     = 3'd5  // Stop bit, entry pushed here
    } frame_state_t;

    // Sampler states
    typedef enum logic {
        HUNT  = 1'b0, // Look for falling edge on the line
        TRACK = 1'b1  // Count ticks within the frame
    } sampler_state_t;

    // One received frame as queued and reported
    typedef struct packed {
        logic [7:0] data;   // Received byte
        logic       perror; // Parity mismatch
        logic       ferror; // Stop bit was low
    } rx_entry_t;

endpackage

// ==== uart_rx_defines.svh ====
`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

// Sample ticks per serial bit
`define UART_OVERSAMPLE 16

// Clock cycles per sample tick, indexed by baud_select
`define UART_DIV_0 2
`define UART_DIV_1 3
`define UART_DIV_2 4
`define UART_DIV_3 5
`define UART_DIV_4 6
`define UART_DIV_5 8
`define UART_DIV_6 10
`define UART_DIV_7 12 // Slowest rate

// Entries held in the output queue
`define UART_RX_QDEPTH 4

// Consumer buffer slots, loaded into the credit counter at reset
`define UART_RX_CREDITS 2

`endif
